/* include/soc_ctrl_defines.svh */
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

`define SOC_N_IO      64       // Number of pads
`define SOC_PADCFG_W  6        // Pad configuration field
`define SOC_PADMUX_W  2        // Pad mux field
`define SOC_PAD_IDX_W 6
`define SOC_NB_MASTER 8        // Masters watched for ready timeouts
`define SOC_JTAG_W    8
`define SOC_NB_CORES    4
`define SOC_NB_CLUSTERS 1

`define REG_INFO          12'h000  // Cores and clusters
`define REG_FCBOOT        12'h004
`define REG_FCFETCH       12'h008
`define REG_WCFGFUN       12'h060  // Indirect pad write
`define REG_RCFGFUN       12'h064  // Indirect pad select
`define REG_JTAGREG       12'h074
`define REG_WD_COUNT      12'h0D0
`define REG_WD_CONTROL    12'h0D4
`define REG_RESET_REASON  12'h0D8
`define REG_RTO_PERIPH    12'h0E0
`define REG_RTO_COUNT     12'h0E4
`define REG_EFPGA_RESET   12'h0E8
`define REG_EFPGA_ENABLE  12'h0EC
`define REG_EFPGA_CONTROL 12'h0F0
`define REG_SOFT_RESET    12'h0FC
`define REG_PAD_BASE      12'h400  // Direct pad window

`define BOOTADDR_RST  32'h1A00_0080
`define WD_COUNT_RST  31'd32768
`define RTO_COUNT_RST 20'h000FF
`define WD_KICK_KEY   16'h6699
`define ERR_RDATA     32'hDEAD_BEEF

`endif

/* verilog/soc_ctrl_pkg.sv */
package soc_ctrl_pkg;

  typedef struct packed {
    logic [11:0] paddr;   // 4 KB window
    logic [31:0] pwdata;
    logic        pwrite;
    logic        psel;
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // One-cycle internal access, valid only in the ACCESS state
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
  } reg_acc_t;

  typedef struct packed {
    logic        hit;     // Address belongs to the block
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } apb_state_e;

endpackage

/* verilog/soc_ctrl_apb_fsm.sv */
`include "soc_ctrl_defines.svh"

module soc_ctrl_apb_fsm (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  soc_ctrl_pkg::apb_req_t apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t apb_rsp_o,
  output soc_ctrl_pkg::reg_acc_t acc_o,
  input  soc_ctrl_pkg::reg_rsp_t rsp_i
);

  import soc_ctrl_pkg::*;

  apb_state_e state_q;

  // Master holds the request steady until pready, so it is passed straight on
  always_comb begin
    acc_o.valid = (state_q == ACCESS);  // Strobe for exactly one cycle
    acc_o.write = apb_req_i.pwrite;
    acc_o.addr  = apb_req_i.paddr;
    acc_o.wdata = apb_req_i.pwdata;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q           <= IDLE;
      apb_rsp_o.prdata  <= '0;
      apb_rsp_o.pready  <= 1'b0;
      apb_rsp_o.pslverr <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (apb_req_i.psel && apb_req_i.penable) begin
            state_q <= ACCESS;
          end
        end
        ACCESS: begin
          // Capture the merged answer of all blocks
          apb_rsp_o.pready <= 1'b1;
          if (rsp_i.hit) begin
            apb_rsp_o.prdata  <= rsp_i.rdata;
            apb_rsp_o.pslverr <= 1'b0;
          end else begin
            apb_rsp_o.prdata  <= `ERR_RDATA;  // Unmapped address
            apb_rsp_o.pslverr <= 1'b1;
          end
          state_q <= DONE;
        end
        DONE: begin
          apb_rsp_o.pready  <= 1'b0;  // One-cycle pready
          apb_rsp_o.pslverr <= 1'b0;
          state_q           <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

/* verilog/soc_ctrl_regs.sv */
`include "soc_ctrl_defines.svh"

module soc_ctrl_regs (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  soc_ctrl_pkg::reg_acc_t  acc_i,
  input  soc_ctrl_pkg::reg_rsp_t  pad_rsp_i,
  input  soc_ctrl_pkg::reg_rsp_t  wd_rsp_i,
  input  soc_ctrl_pkg::reg_rsp_t  rto_rsp_i,
  output soc_ctrl_pkg::reg_rsp_t  rsp_o,
  input  logic [`SOC_JTAG_W-1:0]  jtag_reg_i,
  output logic [`SOC_JTAG_W-1:0]  jtag_reg_o,
  output logic [31:0]             fc_bootaddr_o,
  output logic                    fc_fetchen_o,
  output logic [3:0]              efpga_reset_o,
  output logic [5:0]              efpga_enable_o,
  output logic [31:0]             efpga_control_o,
  output logic                    soft_reset_o
);

  import soc_ctrl_pkg::*;

  logic [1:0][`SOC_JTAG_W-1:0] jtag_sync_q;  // Stage 1 is the synchronized value
  reg_rsp_t                    own_rsp;
  logic                        we;

  assign we = acc_i.valid && acc_i.write;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      jtag_sync_q <= '0;
    end else begin
      jtag_sync_q[0] <= jtag_reg_i;
      jtag_sync_q[1] <= jtag_sync_q[0];
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fc_bootaddr_o   <= `BOOTADDR_RST;
      fc_fetchen_o    <= 1'b1;           // FC runs out of reset
      jtag_reg_o      <= '0;
      efpga_reset_o   <= '0;
      efpga_enable_o  <= '0;
      efpga_control_o <= '0;
      soft_reset_o    <= 1'b0;
    end else begin
      soft_reset_o <= 1'b0;
      if (we) begin
        case (acc_i.addr)
          `REG_FCBOOT:        fc_bootaddr_o   <= acc_i.wdata;
          `REG_FCFETCH:       fc_fetchen_o    <= acc_i.wdata[0];
          `REG_JTAGREG:       jtag_reg_o      <= acc_i.wdata[`SOC_JTAG_W-1:0];
          `REG_EFPGA_RESET:   efpga_reset_o   <= acc_i.wdata[3:0];
          `REG_EFPGA_ENABLE:  efpga_enable_o  <= acc_i.wdata[5:0];
          `REG_EFPGA_CONTROL: efpga_control_o <= acc_i.wdata;
          `REG_SOFT_RESET: begin
            soft_reset_o    <= 1'b1;         // Pad file and timeout see it next cycle
            efpga_reset_o   <= '0;
            efpga_enable_o  <= '0;
            efpga_control_o <= '0;
          end
          default: ;
        endcase
      end
    end
  end

  // Own register decode
  always_comb begin
    own_rsp.hit   = 1'b1;
    own_rsp.rdata = '0;
    case (acc_i.addr)
      `REG_INFO:          own_rsp.rdata = {16'(`SOC_NB_CORES), 16'(`SOC_NB_CLUSTERS)};
      `REG_FCBOOT:        own_rsp.rdata = fc_bootaddr_o;
      `REG_FCFETCH:       own_rsp.rdata[0] = fc_fetchen_o;
      `REG_JTAGREG: begin
        own_rsp.rdata[8 +: `SOC_JTAG_W] = jtag_sync_q[1];
        own_rsp.rdata[0 +: `SOC_JTAG_W] = jtag_reg_o;
      end
      `REG_EFPGA_RESET:   own_rsp.rdata[3:0] = efpga_reset_o;
      `REG_EFPGA_ENABLE:  own_rsp.rdata[5:0] = efpga_enable_o;
      `REG_EFPGA_CONTROL: own_rsp.rdata = efpga_control_o;
      `REG_SOFT_RESET:    own_rsp.rdata = '0;  // Write-only, reads zero
      default:            own_rsp.hit = 1'b0;
    endcase
  end

  // Merge of all blocks; no hit at all means an error
  always_comb begin
    rsp_o.hit   = own_rsp.hit | pad_rsp_i.hit | wd_rsp_i.hit | rto_rsp_i.hit;
    rsp_o.rdata = ({32{own_rsp.hit}} & own_rsp.rdata)
                | ({32{pad_rsp_i.hit}} & pad_rsp_i.rdata)
                | ({32{wd_rsp_i.hit}} & wd_rsp_i.rdata)
                | ({32{rto_rsp_i.hit}} & rto_rsp_i.rdata);
  end

endmodule

/* verilog/soc_pad_cfg.sv */
`include "soc_ctrl_defines.svh"

module soc_pad_cfg (
  input  logic                                       HCLK,
  input  logic                                       HRESETn,
  input  soc_ctrl_pkg::reg_acc_t                     acc_i,
  input  logic                                       soft_reset_i,
  output soc_ctrl_pkg::reg_rsp_t                     rsp_o,
  output logic [`SOC_N_IO-1:0][`SOC_PADCFG_W-1:0]    pad_cfg_o,
  output logic [`SOC_N_IO-1:0][`SOC_PADMUX_W-1:0]    pad_mux_o
);

  logic [`SOC_PAD_IDX_W-1:0] sel_pad_q;
  logic [`SOC_PAD_IDX_W-1:0] wr_idx;
  logic [`SOC_PAD_IDX_W-1:0] dir_idx;
  logic                      dir_hit;
  logic                      dir_ok;
  logic                      we;

  assign we      = acc_i.valid && acc_i.write;
  assign wr_idx  = acc_i.wdata[`SOC_PAD_IDX_W-1:0];
  assign dir_idx = acc_i.addr[2 +: `SOC_PAD_IDX_W];
  assign dir_hit = (acc_i.addr[11:10] == `REG_PAD_BASE >> 10);  // 0x400 - 0x7FC
  assign dir_ok  = (acc_i.addr[9:2] < `SOC_N_IO);              // Pad exists

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel_pad_q <= '0;
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (soft_reset_i) begin
      sel_pad_q <= '0;
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (we) begin
      if (acc_i.addr == `REG_WCFGFUN) begin
        sel_pad_q         <= wr_idx;
        pad_cfg_o[wr_idx] <= acc_i.wdata[24 +: `SOC_PADCFG_W];
        pad_mux_o[wr_idx] <= acc_i.wdata[16 +: `SOC_PADMUX_W];
      end else if (acc_i.addr == `REG_RCFGFUN) begin
        sel_pad_q <= wr_idx;                 // Select only
      end else if (dir_hit && dir_ok) begin
        pad_cfg_o[dir_idx] <= acc_i.wdata[8 +: `SOC_PADCFG_W];
        pad_mux_o[dir_idx] <= acc_i.wdata[0 +: `SOC_PADMUX_W];
      end
    end
  end

  always_comb begin
    rsp_o.hit   = 1'b0;
    rsp_o.rdata = '0;
    if (acc_i.addr == `REG_WCFGFUN || acc_i.addr == `REG_RCFGFUN) begin
      rsp_o.hit                             = 1'b1;
      rsp_o.rdata[0 +: `SOC_PAD_IDX_W]      = sel_pad_q;
      rsp_o.rdata[16 +: `SOC_PADMUX_W]      = pad_mux_o[sel_pad_q];
      rsp_o.rdata[24 +: `SOC_PADCFG_W]      = pad_cfg_o[sel_pad_q];
    end else if (dir_hit) begin
      rsp_o.hit = 1'b1;
      if (dir_ok) begin
        rsp_o.rdata[0 +: `SOC_PADMUX_W] = pad_mux_o[dir_idx];
        rsp_o.rdata[8 +: `SOC_PADCFG_W] = pad_cfg_o[dir_idx];
      end else begin
        rsp_o.rdata = 32'h0095_BEEF;         // No such pad
      end
    end
  end

endmodule

/* verilog/soc_watchdog.sv */
`include "soc_ctrl_defines.svh"

module soc_watchdog (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  soc_ctrl_pkg::reg_acc_t acc_i,
  input  logic                   stoptimer_i,
  output soc_ctrl_pkg::reg_rsp_t rsp_o,
  output logic                   wd_expired_o
);

  logic [30:0] wd_reload_q;
  logic [30:0] wd_cnt_q;
  logic        wd_en_q;
  logic [1:0]  reason_q;
  logic        we;
  logic        kick;
  logic        dec;
  logic        fire;

  assign we   = acc_i.valid && acc_i.write;
  assign kick = we && (acc_i.addr == `REG_WD_CONTROL)
             && (acc_i.wdata[31] || (wd_en_q && acc_i.wdata[15:0] == `WD_KICK_KEY));
  assign dec  = wd_en_q && !stoptimer_i && !kick;
  assign fire = dec && (wd_cnt_q == 31'd1);  // Step from 1 to 0

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_en_q      <= 1'b0;                  // Off at power up
      wd_reload_q  <= `WD_COUNT_RST;
      wd_cnt_q     <= `WD_COUNT_RST;
      wd_expired_o <= 1'b0;
    end else begin
      wd_expired_o <= fire;
      if (we && acc_i.addr == `REG_WD_COUNT && !wd_en_q) wd_reload_q <= acc_i.wdata[30:0];
      if (we && acc_i.addr == `REG_WD_CONTROL && acc_i.wdata[31]) wd_en_q <= 1'b1;
      if (kick) wd_cnt_q <= wd_reload_q;
      else if (dec) wd_cnt_q <= wd_cnt_q - 31'd1;
    end
  end

  // Reset reason: 01 power-on, 10 watchdog, cleared after a read
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reason_q <= 2'b01;
    end else if (fire) begin
      reason_q <= 2'b10;
    end else if (acc_i.valid && !acc_i.write && acc_i.addr == `REG_RESET_REASON) begin
      reason_q <= 2'b00;
    end
  end

  always_comb begin
    rsp_o.hit = 1'b1;
    case (acc_i.addr)
      `REG_WD_COUNT:     rsp_o.rdata = {1'b0, wd_reload_q};
      `REG_WD_CONTROL:   rsp_o.rdata = {wd_en_q, wd_cnt_q};
      `REG_RESET_REASON: rsp_o.rdata = {30'b0, reason_q};
      default: begin
        rsp_o.hit   = 1'b0;
        rsp_o.rdata = '0;
      end
    endcase
  end

endmodule

/* verilog/soc_ready_timeout.sv */
`include "soc_ctrl_defines.svh"

module soc_ready_timeout (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  soc_ctrl_pkg::reg_acc_t   acc_i,
  input  logic                     soft_reset_i,
  input  logic                     start_rto_i,
  input  logic [`SOC_NB_MASTER-1:0] peripheral_rto_i,
  output soc_ctrl_pkg::reg_rsp_t   rsp_o,
  output logic                     rto_o
);

  logic [19:0]                 reload_q;
  logic [19:0]                 cnt_q;
  logic [`SOC_NB_MASTER-1:0]   periph_q;  // Sticky per-master flags
  logic                        we;

  assign we = acc_i.valid && acc_i.write;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reload_q <= `RTO_COUNT_RST;
      cnt_q    <= `RTO_COUNT_RST;
      periph_q <= '0;
      rto_o    <= 1'b0;
    end else begin
      if (!start_rto_i) cnt_q <= reload_q;       // Idle reloads
      else if (cnt_q != '0) cnt_q <= cnt_q - 20'd1;
      rto_o <= (cnt_q == '0);
      if (soft_reset_i) begin
        reload_q <= `RTO_COUNT_RST;
        periph_q <= '0;
      end else begin
        if (we && acc_i.addr == `REG_RTO_COUNT) reload_q <= {acc_i.wdata[19:4], 4'hF};
        if (we && acc_i.addr == `REG_RTO_PERIPH) periph_q <= '0;
        else periph_q <= periph_q | peripheral_rto_i;
      end
    end
  end

  always_comb begin
    rsp_o.hit   = (acc_i.addr == `REG_RTO_PERIPH) || (acc_i.addr == `REG_RTO_COUNT);
    rsp_o.rdata = (acc_i.addr == `REG_RTO_COUNT) ? 32'(reload_q) : 32'(periph_q);
  end

endmodule

/* verilog/apb_soc_ctrl.sv */
`include "soc_ctrl_defines.svh"

module apb_soc_ctrl (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  soc_ctrl_pkg::apb_req_t                  apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t                  apb_rsp_o,
  input  logic                                    stoptimer_i,
  input  logic                                    start_rto_i,
  input  logic [`SOC_NB_MASTER-1:0]               peripheral_rto_i,
  input  logic [`SOC_JTAG_W-1:0]                  jtag_reg_i,
  output logic [`SOC_JTAG_W-1:0]                  jtag_reg_o,
  output logic [31:0]                             fc_bootaddr_o,
  output logic                                    fc_fetchen_o,
  output logic [`SOC_N_IO-1:0][`SOC_PADCFG_W-1:0] pad_cfg_o,
  output logic [`SOC_N_IO-1:0][`SOC_PADMUX_W-1:0] pad_mux_o,
  output logic [3:0]                              efpga_reset_o,
  output logic [5:0]                              efpga_enable_o,
  output logic [31:0]                             efpga_control_o,
  output logic                                    wd_expired_o,
  output logic                                    rto_o,
  output logic                                    soft_reset_o
);

  import soc_ctrl_pkg::*;

  reg_acc_t acc;      // Shared access strobe
  reg_rsp_t regs_rsp; // Merged answer
  reg_rsp_t pad_rsp;
  reg_rsp_t wd_rsp;
  reg_rsp_t rto_rsp;

  soc_ctrl_apb_fsm u_apb_fsm (
    .HCLK, .HRESETn, .apb_req_i, .apb_rsp_o, .acc_o(acc), .rsp_i(regs_rsp)
  );

  soc_ctrl_regs u_regs (
    .HCLK, .HRESETn, .acc_i(acc), .pad_rsp_i(pad_rsp), .wd_rsp_i(wd_rsp),
    .rto_rsp_i(rto_rsp), .rsp_o(regs_rsp), .jtag_reg_i, .jtag_reg_o, .fc_bootaddr_o,
    .fc_fetchen_o, .efpga_reset_o, .efpga_enable_o, .efpga_control_o, .soft_reset_o
  );

  soc_pad_cfg u_pad_cfg (
    .HCLK, .HRESETn, .acc_i(acc), .soft_reset_i(soft_reset_o), .rsp_o(pad_rsp),
    .pad_cfg_o, .pad_mux_o
  );

  soc_watchdog u_watchdog (
    .HCLK, .HRESETn, .acc_i(acc), .stoptimer_i, .rsp_o(wd_rsp), .wd_expired_o
  );

  soc_ready_timeout u_ready_timeout (
    .HCLK, .HRESETn, .acc_i(acc), .soft_reset_i(soft_reset_o), .start_rto_i,
    .peripheral_rto_i, .rsp_o(rto_rsp), .rto_o
  );

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
  output logic HCLK,
  output logic HRESETn
);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;  // Period 20
  end

  initial begin
    HRESETn = 1'b0;
    repeat (16) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;            // Released away from the rising edge
  end

endmodule

/* bench/tb_apb_soc_ctrl.sv */
`include "soc_ctrl_defines.svh"

module tb_apb_soc_ctrl;

  import soc_ctrl_pkg::*;

  localparam int PREADY_LIMIT = 20;
  localparam int PULSE_LIMIT  = 300;  // Cycles for watchdog and ready timeout

  typedef struct packed {
    logic        wr;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;  // Checked on reads only
    logic        exp_err;
  } tbl_entry_t;

  logic                                    HCLK;
  logic                                    HRESETn;
  apb_req_t                                apb_req;
  apb_rsp_t                                apb_rsp;
  logic                                    stoptimer;
  logic                                    start_rto;
  logic [`SOC_NB_MASTER-1:0]               periph_rto;
  logic [`SOC_JTAG_W-1:0]                  jtag_in;
  logic [`SOC_JTAG_W-1:0]                  jtag_out;
  logic [31:0]                             fc_bootaddr;
  logic                                    fc_fetchen;
  logic [`SOC_N_IO-1:0][`SOC_PADCFG_W-1:0] pad_cfg;
  logic [`SOC_N_IO-1:0][`SOC_PADMUX_W-1:0] pad_mux;
  logic [3:0]                              efpga_reset;
  logic [5:0]                              efpga_enable;
  logic [31:0]                             efpga_control;
  logic                                    wd_expired;
  logic                                    rto;
  logic                                    soft_reset;

  tbl_entry_t                 table_q[$];
  logic [`SOC_PADCFG_W-1:0]   exp_cfg [`SOC_N_IO];  // Pad model
  logic [`SOC_PADMUX_W-1:0]   exp_mux [`SOC_N_IO];
  int                         soft_pulses = 0;
  logic [31:0]                boot_val;
  logic [31:0]                ctrl_val;
  logic [7:0]                 jtag_val;

  tb_clock_gen u_clock_gen (.HCLK, .HRESETn);

  apb_soc_ctrl u_apb_soc_ctrl (
    .HCLK, .HRESETn, .apb_req_i(apb_req), .apb_rsp_o(apb_rsp), .stoptimer_i(stoptimer),
    .start_rto_i(start_rto), .peripheral_rto_i(periph_rto), .jtag_reg_i(jtag_in),
    .jtag_reg_o(jtag_out), .fc_bootaddr_o(fc_bootaddr), .fc_fetchen_o(fc_fetchen),
    .pad_cfg_o(pad_cfg), .pad_mux_o(pad_mux), .efpga_reset_o(efpga_reset),
    .efpga_enable_o(efpga_enable), .efpga_control_o(efpga_control),
    .wd_expired_o(wd_expired), .rto_o(rto), .soft_reset_o(soft_reset)
  );

  always @(negedge HCLK) begin
    if (HRESETn && soft_reset) soft_pulses++;  // Cycles with soft reset high
  end

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not arrive in time", what);
    abort_run();
  endtask

  task automatic check_rsp(input logic [11:0] addr, input apb_rsp_t got, input apb_rsp_t exp,
                           input logic chk_data);
    if (got.pslverr !== exp.pslverr) begin
      $display("MISMATCH pslverr at %h: got %h expected %h", addr, got.pslverr, exp.pslverr);
      abort_run();
    end else if (chk_data && got.prdata !== exp.prdata) begin
      $display("MISMATCH prdata at %h: got %h expected %h", addr, got.prdata, exp.prdata);
      abort_run();
    end
  endtask

  task automatic check_pad(input int idx, input logic [`SOC_PADCFG_W-1:0] cfg,
                           input logic [`SOC_PADMUX_W-1:0] mux);
    if (pad_cfg[idx] !== cfg) begin
      $display("MISMATCH pad_cfg_o[%0d]: got %h expected %h", idx, pad_cfg[idx], cfg);
      abort_run();
    end else if (pad_mux[idx] !== mux) begin
      $display("MISMATCH pad_mux_o[%0d]: got %h expected %h", idx, pad_mux[idx], mux);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_all_pads();
    for (int i = 0; i < `SOC_N_IO; i++) check_pad(i, exp_cfg[i], exp_mux[i]);
  endtask

  function automatic void reset_pad_model();
    for (int i = 0; i < `SOC_N_IO; i++) begin
      exp_cfg[i] = '1;
      exp_mux[i] = '0;
    end
  endfunction

  function automatic void add_write(input logic [11:0] addr, input logic [31:0] data,
                                    input logic err);
    table_q.push_back('{1'b1, addr, data, 32'h0, err});
  endfunction

  function automatic void expect_read(input logic [11:0] addr, input logic [31:0] data,
                                      input logic err);
    table_q.push_back('{1'b0, addr, 32'h0, data, err});
  endfunction

  // One APB transfer, setup then access phase, response taken when pready is seen
  task automatic apb_transfer(input tbl_entry_t e, output apb_rsp_t got);
    int cnt;
    cnt = 0;
    @(negedge HCLK);
    apb_req.paddr   = e.addr;
    apb_req.pwdata  = e.wdata;
    apb_req.pwrite  = e.wr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge HCLK);
    apb_req.penable = 1'b1;
    @(negedge HCLK);
    while (apb_rsp.pready !== 1'b1 && cnt < PREADY_LIMIT) begin
      @(negedge HCLK);
      cnt++;
    end
    if (apb_rsp.pready !== 1'b1) begin
      report_timeout("pready");
    end else begin
      got             = apb_rsp;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic apply_table();
    apb_rsp_t got;
    apb_rsp_t exp;
    foreach (table_q[i]) begin
      apb_transfer(table_q[i], got);
      exp = '{table_q[i].exp_rdata, 1'b1, table_q[i].exp_err};
      check_rsp(table_q[i].addr, got, exp, !table_q[i].wr);
    end
    table_q.delete();
  endtask

  task automatic wait_reset();
    int cnt;
    cnt = 0;
    while (HRESETn !== 1'b1 && cnt < 100) begin
      @(negedge HCLK);
      cnt++;
    end
    if (HRESETn !== 1'b1) report_timeout("reset release");
  endtask

  task automatic wait_expiry();
    int cnt;
    cnt = 0;
    while (wd_expired !== 1'b1 && cnt < PULSE_LIMIT) begin
      @(negedge HCLK);
      cnt++;
    end
    if (wd_expired !== 1'b1) report_timeout("wd_expired_o");
  endtask

  task automatic wait_rto();
    int cnt;
    cnt = 0;
    while (rto !== 1'b1 && cnt < PULSE_LIMIT) begin
      @(negedge HCLK);
      cnt++;
    end
    if (rto !== 1'b1) report_timeout("rto_o");
  endtask

  initial begin
    int          idx;
    logic [31:0] wd;
    logic [5:0]  cfg;
    logic [1:0]  mux;
    void'($urandom(32'h551e));
    apb_req    = '0;
    stoptimer  = 1'b0;
    start_rto  = 1'b0;
    periph_rto = '0;
    jtag_in    = 8'h5A;
    reset_pad_model();
    wait_reset();
    boot_val = $urandom;
    ctrl_val = $urandom;
    jtag_val = 8'($urandom);

    expect_read(`REG_INFO, 32'h0004_0001, 1'b0);  // 4 cores, 1 cluster
    expect_read(`REG_FCBOOT, 32'h1A00_0080, 1'b0);
    expect_read(`REG_FCFETCH, 32'h1, 1'b0);
    expect_read(`REG_RESET_REASON, 32'h1, 1'b0);
    expect_read(`REG_RESET_REASON, 32'h0, 1'b0);  // Cleared by the first read
    add_write(`REG_FCBOOT, boot_val, 1'b0);
    add_write(`REG_EFPGA_CONTROL, ctrl_val, 1'b0);
    add_write(`REG_JTAGREG, 32'(jtag_val), 1'b0);
    expect_read(`REG_FCBOOT, boot_val, 1'b0);
    expect_read(`REG_EFPGA_CONTROL, ctrl_val, 1'b0);
    expect_read(`REG_JTAGREG, {16'h0, jtag_in, jtag_val}, 1'b0);
    apply_table();
    check_word("fc_bootaddr_o", fc_bootaddr, boot_val);
    check_word("fc_fetchen_o", 32'(fc_fetchen), 32'h1);
    check_word("efpga_control_o", efpga_control, ctrl_val);
    check_word("jtag_reg_o", 32'(jtag_out), 32'(jtag_val));
    check_all_pads();

    for (int k = 0; k < 6; k++) begin
      idx = $urandom_range(`SOC_N_IO - 1);
      wd  = $urandom;
      add_write(12'(`REG_PAD_BASE + 4 * idx), wd, 1'b0);
      expect_read(12'(`REG_PAD_BASE + 4 * idx), wd & 32'h0000_3F03, 1'b0);
      exp_cfg[idx] = wd[13:8];
      exp_mux[idx] = wd[1:0];
    end
    cfg = 6'($urandom);
    mux = 2'($urandom);
    wd  = {2'b00, cfg, 6'b0, mux, 10'b0, 6'd10};     // Pad 10, indirect layout
    add_write(`REG_WCFGFUN, wd, 1'b0);
    expect_read(`REG_RCFGFUN, wd, 1'b0);
    exp_cfg[10] = cfg;
    exp_mux[10] = mux;
    add_write(12'h518, 32'hFFFF_FFFF, 1'b0);          // Pad 70 does not exist
    expect_read(12'h518, 32'h0095_BEEF, 1'b0);
    expect_read(12'h200, 32'hDEAD_BEEF, 1'b1);        // Unmapped
    add_write(12'h200, $urandom, 1'b1);
    expect_read(`REG_FCBOOT, boot_val, 1'b0);
    apply_table();
    check_all_pads();

    add_write(`REG_WD_COUNT, 32'd40, 1'b0);
    expect_read(`REG_WD_COUNT, 32'd40, 1'b0);
    add_write(`REG_WD_CONTROL, 32'h8000_0000, 1'b0);  // Enable and load
    apply_table();
    wait_expiry();
    expect_read(`REG_RESET_REASON, 32'h2, 1'b0);
    add_write(`REG_WD_COUNT, 32'd100, 1'b0);          // Locked while enabled
    expect_read(`REG_WD_COUNT, 32'd40, 1'b0);
    add_write(`REG_RTO_COUNT, 32'h30, 1'b0);
    expect_read(`REG_RTO_COUNT, 32'h3F, 1'b0);
    apply_table();
    check_word("rto_o", 32'(rto), 32'h0);
    @(negedge HCLK);
    start_rto = 1'b1;
    wait_rto();
    start_rto  = 1'b0;
    periph_rto = 8'h04;
    @(negedge HCLK);
    periph_rto = '0;
    expect_read(`REG_RTO_PERIPH, 32'h4, 1'b0);
    add_write(`REG_RTO_PERIPH, 32'h0, 1'b0);
    expect_read(`REG_RTO_PERIPH, 32'h0, 1'b0);
    add_write(`REG_EFPGA_RESET, 32'hA, 1'b0);
    add_write(`REG_EFPGA_ENABLE, 32'h2A, 1'b0);
    expect_read(`REG_EFPGA_RESET, 32'hA, 1'b0);
    expect_read(`REG_EFPGA_ENABLE, 32'h2A, 1'b0);
    apply_table();
    check_word("efpga_reset_o", 32'(efpga_reset), 32'hA);
    check_word("efpga_enable_o", 32'(efpga_enable), 32'h2A);

    check_word("soft_reset_o count", 32'(soft_pulses), 32'h0);
    add_write(`REG_SOFT_RESET, 32'h1, 1'b0);
    expect_read(`REG_EFPGA_RESET, 32'h0, 1'b0);
    expect_read(`REG_EFPGA_ENABLE, 32'h0, 1'b0);
    expect_read(`REG_EFPGA_CONTROL, 32'h0, 1'b0);
    expect_read(`REG_RTO_COUNT, 32'hFF, 1'b0);
    expect_read(`REG_RCFGFUN, 32'h3F00_0000, 1'b0);  // Pad 0 selected again
    expect_read(`REG_FCBOOT, boot_val, 1'b0);
    apply_table();
    check_word("soft_reset_o count", 32'(soft_pulses), 32'h1);
    check_word("efpga_control_o", efpga_control, 32'h0);
    check_word("efpga_reset_o", 32'(efpga_reset), 32'h0);
    check_word("efpga_enable_o", 32'(efpga_enable), 32'h0);
    reset_pad_model();
    check_all_pads();

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
verilog/soc_ctrl_pkg.sv
verilog/soc_ctrl_apb_fsm.sv
verilog/soc_ctrl_regs.sv
verilog/soc_pad_cfg.sv
verilog/soc_watchdog.sv
verilog/soc_ready_timeout.sv
verilog/apb_soc_ctrl.sv
bench/tb_clock_gen.sv
bench/tb_apb_soc_ctrl.sv
